// ==== verilog/kbd_pkg.sv ====
package kbd_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Bus word addresses
    typedef enum logic [3:0] {
        PORT_DATA    = 4'h0,
        PORT_CONTROL = 4'h1
    } port_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // Control write bits
    localparam int CTRL_IRQ_EN  = 0;
    localparam int CTRL_FLUSH   = 1;
    localparam int CTRL_CLR_ERR = 2;

    // Control read status bits
    localparam int STAT_FRAME_ERR = 8;
    localparam int STAT_OVERFLOW  = 9;

    // Key event FIFO, break flag plus virtual key
    localparam int FIFO_ADDR_W = 4;
    localparam int FIFO_W      = 9;

    // System clocks without a PS/2 clock edge before a partial frame is dropped
    localparam int PS2_TIMEOUT = 200;

    // Set 2 prefix bytes
    localparam byte_t SC_EXTENDED = 8'hE0;
    localparam byte_t SC_BREAK    = 8'hF0;

endpackage

// ==== verilog/kbd_event_if.sv ====
`timescale 1ns/1ps

interface kbd_event_if;
    import kbd_pkg::*;

    logic  valid;
    logic  is_break;
    logic  extended;
    byte_t code;

    modport source (output valid, output is_break, output extended, output code);
    modport sink (input valid, input is_break, input extended, input code);

endinterface

// ==== verilog/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            ps2_clk_i,
    input  logic            ps2_data_i,
    output kbd_pkg::byte_t  data_o,
    output logic            valid_o,
    output logic            frame_err_o
);
    import kbd_pkg::*;

    localparam int TO_W = $clog2(PS2_TIMEOUT + 1);

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       fall;
    logic       timeout;
    rx_state_t  state;
    logic [2:0] bit_cnt;
    logic [TO_W-1:0] quiet_cnt;
    byte_t      shift_r;
    logic       parity_ok;

    // Two flop synchronizers, lines idle high
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_i};
            data_sync <= {data_sync[0], ps2_data_i};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall    = clk_prev && !clk_sync[1];
    assign timeout = (quiet_cnt == TO_W'(PS2_TIMEOUT));

    always_ff @(posedge clk_i) begin
        if (reset_i || fall || state == RX_IDLE) begin
            quiet_cnt <= '0;
        end else if (!timeout) begin
            quiet_cnt <= quiet_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
            if (fall) begin
                case (state)
                    RX_IDLE: begin
                        // Start bit is a low data line
                        if (!data_sync[1]) begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: state <= RX_STOP;
                    RX_STOP: begin
                        state <= RX_IDLE;
                        if (parity_ok && data_sync[1]) begin
                            valid_o <= 1'b1;
                        end else begin
                            frame_err_o <= 1'b1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end else if (timeout) begin
                state <= RX_IDLE;
            end
        end
    end

    // LSB first shift, odd parity over data and parity bit
    always_ff @(posedge clk_i) begin
        if (fall && state == RX_DATA) begin
            shift_r <= {data_sync[1], shift_r[7:1]};
        end
        if (fall && state == RX_PARITY) begin
            parity_ok <= ^{shift_r, data_sync[1]};
        end
    end

    assign data_o = shift_r;

endmodule

// ==== verilog/ps2_kbd.sv ====
`timescale 1ns/1ps

module ps2_kbd (
    input  logic               clk_i,
    input  logic               reset_i,
    input  kbd_pkg::byte_t     data_i,
    input  logic               valid_i,
    kbd_event_if.source        ev
);
    import kbd_pkg::*;

    logic ext_pend;
    logic brk_pend;
    logic is_prefix;

    assign is_prefix = (data_i == SC_EXTENDED) || (data_i == SC_BREAK);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ext_pend <= 1'b0;
            brk_pend <= 1'b0;
            ev.valid <= 1'b0;
        end else begin
            ev.valid <= 1'b0;
            if (valid_i) begin
                if (data_i == SC_EXTENDED) begin
                    ext_pend <= 1'b1;
                end else if (data_i == SC_BREAK) begin
                    brk_pend <= 1'b1;
                end else begin
                    // Final byte of a sequence, flags are consumed
                    ev.valid <= 1'b1;
                    ext_pend <= 1'b0;
                    brk_pend <= 1'b0;
                end
            end
        end
    end

    // Event payload
    always_ff @(posedge clk_i) begin
        if (valid_i && !is_prefix) begin
            ev.code     <= data_i;
            ev.is_break <= brk_pend;
            ev.extended <= ext_pend;
        end
    end

endmodule

// ==== verilog/keycode_rom.sv ====
`timescale 1ns/1ps

module keycode_rom (
    input  logic                       clk_i,
    input  logic                       reset_i,
    kbd_event_if.sink                  ev,
    output logic [kbd_pkg::FIFO_W-1:0] wr_data_o,
    output logic                       wr_en_o
);
    import kbd_pkg::*;

    byte_t vk;

    // Index is {extended, scan code}
    always_comb begin
        case ({ev.extended, ev.code})
            9'h01C: vk = "A";
            9'h032: vk = "B";
            9'h021: vk = "C";
            9'h023: vk = "D";
            9'h024: vk = "E";
            9'h02B: vk = "F";
            9'h034: vk = "G";
            9'h033: vk = "H";
            9'h043: vk = "I";
            9'h03B: vk = "J";
            9'h042: vk = "K";
            9'h04B: vk = "L";
            9'h03A: vk = "M";
            9'h031: vk = "N";
            9'h044: vk = "O";
            9'h04D: vk = "P";
            9'h015: vk = "Q";
            9'h02D: vk = "R";
            9'h01B: vk = "S";
            9'h02C: vk = "T";
            9'h03C: vk = "U";
            9'h02A: vk = "V";
            9'h01D: vk = "W";
            9'h022: vk = "X";
            9'h035: vk = "Y";
            9'h01A: vk = "Z";
            9'h045: vk = "0";
            9'h016: vk = "1";
            9'h01E: vk = "2";
            9'h026: vk = "3";
            9'h025: vk = "4";
            9'h02E: vk = "5";
            9'h036: vk = "6";
            9'h03D: vk = "7";
            9'h03E: vk = "8";
            9'h046: vk = "9";
            9'h029: vk = 8'h20;
            9'h05A: vk = 8'h0D;
            9'h066: vk = 8'h08;
            9'h076: vk = 8'h1B;
            // Extended arrows up, down, left, right
            9'h175: vk = 8'h80;
            9'h172: vk = 8'h81;
            9'h16B: vk = 8'h82;
            9'h174: vk = 8'h83;
            default: vk = 8'h00;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= ev.valid && (vk != 8'h00);
        end
    end

    always_ff @(posedge clk_i) begin
        wr_data_o <= {ev.is_break, vk};
    end

endmodule

// ==== verilog/kbd_fifo.sv ====
`timescale 1ns/1ps

module kbd_fifo #(
    parameter int WIDTH  = 9,
    parameter int ADDR_W = 4
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] wr_data_i,
    input  logic             wr_en_i,
    input  logic             rd_en_i,
    input  logic             flush_i,
    output logic [WIDTH-1:0] rd_data_o,
    output logic             not_empty_o,
    output logic             overflow_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              full;
    logic              do_wr;
    logic              do_rd;

    assign full        = (count == (ADDR_W + 1)'(DEPTH));
    assign not_empty_o = (count != '0);
    assign do_wr       = wr_en_i && !full && !flush_i;
    assign do_rd       = rd_en_i && not_empty_o && !flush_i;
    // Write into a full FIFO is dropped, older entries stay
    assign overflow_o  = wr_en_i && full && !flush_i;
    assign rd_data_o   = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ADDR_W + 1)'(do_wr) - (ADDR_W + 1)'(do_rd);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

// ==== verilog/kbd_regs.sv ====
`timescale 1ns/1ps

module kbd_regs (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       chip_select_i,
    input  logic [3:0]                 addr_i,
    input  logic                       read_enable_i,
    input  kbd_pkg::word_t             write_data_i,
    input  logic [3:0]                 write_mask_i,
    output kbd_pkg::word_t             read_data_o,
    output logic                       interrupt_o,
    input  logic [kbd_pkg::FIFO_W-1:0] fifo_data_i,
    input  logic                       fifo_not_empty_i,
    input  logic                       overflow_i,
    input  logic                       frame_err_i,
    output logic                       fifo_pop_o,
    output logic                       fifo_flush_o
);
    import kbd_pkg::*;

    port_t port;
    logic  rd_stb;
    logic  ctrl_wr;
    logic  clr_err;
    logic  irq_en;
    logic  frame_err;
    logic  overflow;
    word_t data_word;
    word_t ctrl_word;

    assign port    = port_t'(addr_i);
    assign rd_stb  = chip_select_i && read_enable_i;
    assign ctrl_wr = chip_select_i && !read_enable_i && write_mask_i[0]
                     && (port == PORT_CONTROL);
    assign clr_err = ctrl_wr && write_data_i[CTRL_CLR_ERR];

    assign fifo_pop_o   = rd_stb && (port == PORT_DATA) && fifo_not_empty_i;
    assign fifo_flush_o = ctrl_wr && write_data_i[CTRL_FLUSH];
    assign interrupt_o  = irq_en && fifo_not_empty_i;

    // Valid at 16, break at 8, key in the low byte
    assign data_word = {15'b0, fifo_not_empty_i, 7'b0,
                        fifo_not_empty_i ? fifo_data_i : {FIFO_W{1'b0}}};

    always_comb begin
        ctrl_word                 = '0;
        ctrl_word[CTRL_IRQ_EN]    = irq_en;
        ctrl_word[STAT_FRAME_ERR] = frame_err;
        ctrl_word[STAT_OVERFLOW]  = overflow;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_en      <= 1'b0;
            frame_err   <= 1'b0;
            overflow    <= 1'b0;
            read_data_o <= '0;
        end else begin
            if (ctrl_wr) begin
                irq_en <= write_data_i[CTRL_IRQ_EN];
            end
            // A new error wins over a clear in the same cycle
            frame_err <= frame_err_i || (frame_err && !clr_err);
            overflow  <= overflow_i || (overflow && !clr_err);
            if (rd_stb) begin
                case (port)
                    PORT_DATA:    read_data_o <= data_word;
                    PORT_CONTROL: read_data_o <= ctrl_word;
                    default:      read_data_o <= '0;
                endcase
            end
        end
    end

endmodule

// ==== verilog/kbd_controller.sv ====
`timescale 1ns/1ps

module kbd_controller (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           ps2_clk_i,
    input  logic           ps2_data_i,
    input  logic           chip_select_i,
    input  logic [3:0]     addr_i,
    input  logic           read_enable_i,
    input  kbd_pkg::word_t write_data_i,
    input  logic [3:0]     write_mask_i,
    output kbd_pkg::word_t read_data_o,
    output logic           interrupt_o
);
    import kbd_pkg::*;

    byte_t             rx_data;
    logic              rx_valid;
    logic              rx_frame_err;
    logic [FIFO_W-1:0] rom_data;
    logic              rom_wr;
    logic [FIFO_W-1:0] fifo_data;
    logic              fifo_not_empty;
    logic              fifo_overflow;
    logic              fifo_pop;
    logic              fifo_flush;

    kbd_event_if ev ();

    ps2_rx u_rx (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ps2_clk_i   (ps2_clk_i),
        .ps2_data_i  (ps2_data_i),
        .data_o      (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (rx_frame_err)
    );

    ps2_kbd u_kbd (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (rx_data),
        .valid_i (rx_valid),
        .ev      (ev.source)
    );

    keycode_rom u_rom (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .ev        (ev.sink),
        .wr_data_o (rom_data),
        .wr_en_o   (rom_wr)
    );

    kbd_fifo #(
        .WIDTH  (FIFO_W),
        .ADDR_W (FIFO_ADDR_W)
    ) u_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wr_data_i   (rom_data),
        .wr_en_i     (rom_wr),
        .rd_en_i     (fifo_pop),
        .flush_i     (fifo_flush),
        .rd_data_o   (fifo_data),
        .not_empty_o (fifo_not_empty),
        .overflow_o  (fifo_overflow)
    );

    kbd_regs u_regs (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .chip_select_i    (chip_select_i),
        .addr_i           (addr_i),
        .read_enable_i    (read_enable_i),
        .write_data_i     (write_data_i),
        .write_mask_i     (write_mask_i),
        .read_data_o      (read_data_o),
        .interrupt_o      (interrupt_o),
        .fifo_data_i      (fifo_data),
        .fifo_not_empty_i (fifo_not_empty),
        .overflow_i       (fifo_overflow),
        .frame_err_i      (rx_frame_err),
        .fifo_pop_o       (fifo_pop),
        .fifo_flush_o     (fifo_flush)
    );

endmodule

// ==== testbench/kbd_controller_assert.sv ====
`timescale 1ns/1ps

module kbd_controller_assert (
    input logic                        clk_i,
    input logic                        reset_i,
    input logic                        irq_en_i,
    input logic                        interrupt_i,
    input logic [kbd_pkg::FIFO_ADDR_W:0] fifo_count_i,
    input logic                        rx_valid_i,
    input logic                        rom_wr_i
);
    import kbd_pkg::*;

    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    // Interrupt only with the enable set
    assert property (@(posedge clk_i) disable iff (reset_i) interrupt_i |-> irq_en_i)
        else $error("interrupt_o high while irq enable is clear");

    assert property (@(posedge clk_i) disable iff (reset_i)
                     fifo_count_i <= (FIFO_ADDR_W + 1)'(DEPTH))
        else $error("FIFO count above depth");

    // Byte and write strobes are single cycle pulses
    assert property (@(posedge clk_i) disable iff (reset_i) rx_valid_i |=> !rx_valid_i)
        else $error("ps2_rx valid_o high in two consecutive cycles");

    assert property (@(posedge clk_i) disable iff (reset_i) rom_wr_i |=> !rom_wr_i)
        else $error("keycode_rom wr_en_o high in two consecutive cycles");

endmodule

bind kbd_controller kbd_controller_assert u_assert (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .irq_en_i     (u_regs.irq_en),
    .interrupt_i  (interrupt_o),
    .fifo_count_i (u_fifo.count),
    .rx_valid_i   (rx_valid),
    .rom_wr_i     (rom_wr)
);

// ==== testbench/kbd_controller_tb.sv ====
`timescale 1ns/1ps

module kbd_controller_tb;
    import kbd_pkg::*;

    localparam int HALF       = 5;
    localparam int MAX_CYCLES = 60000;
    localparam int DEPTH      = 2 ** FIFO_ADDR_W;

    logic       clk = 1'b0;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic       chip_select;
    logic [3:0] addr;
    logic       read_enable;
    word_t      write_data;
    logic [3:0] write_mask;
    word_t      read_data;
    logic       interrupt;

    int seed = 32'hd885;
    int checks = 0;
    int errors = 0;
    int err_mark = 0;
    int cycles = 0;

    // Reference model state
    logic [FIFO_W-1:0] exp_q[$];
    logic m_irq_en = 1'b0;
    logic m_frame_err = 1'b0;
    logic m_overflow = 1'b0;

    // Set 2 scan codes for A to Z, 0 to 9, space/enter/backspace/esc, arrows
    byte_t letter_sc[26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
                             8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
                             8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    byte_t digit_sc[10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
    byte_t special_sc[4] = '{8'h29, 8'h5A, 8'h66, 8'h76};
    byte_t arrow_sc[4] = '{8'h75, 8'h72, 8'h6B, 8'h74};

    kbd_controller uut (
        .clk_i         (clk),
        .reset_i       (reset),
        .ps2_clk_i     (ps2_clk),
        .ps2_data_i    (ps2_data),
        .chip_select_i (chip_select),
        .addr_i        (addr),
        .read_enable_i (read_enable),
        .write_data_i  (write_data),
        .write_mask_i  (write_mask),
        .read_data_o   (read_data),
        .interrupt_o   (interrupt)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check(input word_t got, input word_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s finished with %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    function automatic byte_t model_vk(input logic ext, input byte_t code);
        byte_t vk;
        vk = 8'h00;
        if (ext) begin
            for (int i = 0; i < 4; i++) begin
                if (code == arrow_sc[i]) vk = 8'h80 + 8'(i);
            end
        end else begin
            for (int i = 0; i < 26; i++) begin
                if (code == letter_sc[i]) vk = 8'h41 + 8'(i);
            end
            for (int i = 0; i < 10; i++) begin
                if (code == digit_sc[i]) vk = 8'h30 + 8'(i);
            end
            if (code == special_sc[0]) vk = 8'h20;
            if (code == special_sc[1]) vk = 8'h0D;
            if (code == special_sc[2]) vk = 8'h08;
            if (code == special_sc[3]) vk = 8'h1B;
        end
        return vk;
    endfunction

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_frame(input byte_t code, input logic bad_parity, input int nbits);
        logic [10:0] frame;
        frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};
        repeat (nbits) begin
            ps2_data = frame[0];
            frame = frame >> 1;
            tick(HALF);
            ps2_clk = 1'b0;
            tick(HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic bus_read(input port_t port, output word_t data);
        chip_select = 1'b1;
        read_enable = 1'b1;
        addr = port;
        tick(1);
        chip_select = 1'b0;
        read_enable = 1'b0;
        data = read_data;
    endtask

    task automatic ctrl_write(input word_t data);
        chip_select = 1'b1;
        read_enable = 1'b0;
        addr = PORT_CONTROL;
        write_data = data;
        write_mask = 4'h1;
        tick(1);
        chip_select = 1'b0;
        write_mask = 4'h0;
        m_irq_en = data[CTRL_IRQ_EN];
        if (data[CTRL_FLUSH]) exp_q.delete();
        if (data[CTRL_CLR_ERR]) begin
            m_frame_err = 1'b0;
            m_overflow = 1'b0;
        end
    endtask

    task automatic check_ctrl();
        word_t got;
        word_t exp;
        bus_read(PORT_CONTROL, got);
        exp = '0;
        exp[CTRL_IRQ_EN] = m_irq_en;
        exp[STAT_FRAME_ERR] = m_frame_err;
        exp[STAT_OVERFLOW] = m_overflow;
        check(got, exp, "control read");
    endtask

    // Reads every expected entry, then one read on the empty FIFO
    task automatic drain_fifo();
        word_t got;
        logic [FIFO_W-1:0] exp;
        while (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            bus_read(PORT_DATA, got);
            check(got, {15'b0, 1'b1, 7'b0, exp}, "data read");
        end
        bus_read(PORT_DATA, got);
        check(got, 32'h0, "data read on empty FIFO");
    endtask

    task automatic send_key(input logic ext, input logic brk, input byte_t code);
        byte_t vk;
        logic pushed;
        int waited;
        vk = model_vk(ext, code);
        pushed = (vk != 8'h00) && (exp_q.size() < DEPTH);
        if (ext) send_frame(SC_EXTENDED, 1'b0, 11);
        if (brk) send_frame(SC_BREAK, 1'b0, 11);
        send_frame(code, 1'b0, 11);
        if (pushed) exp_q.push_back({brk, vk});
        else if (vk != 8'h00) m_overflow = 1'b1;
        if (pushed && m_irq_en) begin
            // 5 cycles since the stop edge already, 10 allowed
            waited = 0;
            while (!interrupt && waited < 5) begin
                tick(1);
                waited++;
            end
        end else begin
            tick(10);
        end
        check(32'(interrupt), 32'(m_irq_en && exp_q.size() != 0), "interrupt after key");
    endtask

    task automatic random_key(output logic ext, output byte_t code);
        int r;
        int idx;
        r = $random(seed);
        idx = {24'b0, r[15:8]};
        ext = 1'b0;
        case (r[1:0])
            2'd0: code = letter_sc[idx % 26];
            2'd1: begin
                if (r[16]) code = special_sc[idx % 4];
                else code = digit_sc[idx % 10];
            end
            2'd2: begin
                ext = 1'b1;
                code = arrow_sc[idx % 4];
            end
            default: begin
                // Any byte, mostly unmapped
                ext = r[16];
                code = r[15:8];
                if (code == SC_EXTENDED || code == SC_BREAK) code = 8'h12;
            end
        endcase
    endtask

    function automatic byte_t random_letter();
        int idx;
        idx = $unsigned($random(seed)) % 26;
        return letter_sc[idx];
    endfunction

    initial begin
        logic ext;
        byte_t code;
        reset = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        chip_select = 1'b0;
        addr = 4'h0;
        read_enable = 1'b0;
        write_data = '0;
        write_mask = 4'h0;
        tick(4);
        reset = 1'b0;
        tick(1);

        check(32'(interrupt), 32'h0, "interrupt after reset");
        drain_fifo();
        check_ctrl();
        end_test(1, "reset state");

        ctrl_write(32'h1);
        for (int i = 0; i < 20; i++) begin
            random_key(ext, code);
            send_key(ext, 1'b0, code);
            drain_fifo();
            send_key(ext, 1'b1, code);
            drain_fifo();
        end
        end_test(2, "random make and break");

        for (int i = 0; i < 3; i++) begin
            send_frame(random_letter(), 1'b1, 11);
            m_frame_err = 1'b1;
        end
        tick(10);
        check_ctrl();
        drain_fifo();
        ctrl_write(32'h5);
        check_ctrl();
        for (int i = 0; i < 2; i++) begin
            send_key(1'b0, 1'b0, random_letter());
            drain_fifo();
        end
        end_test(3, "parity error");

        for (int i = 0; i < 20; i++) begin
            send_key(1'b0, 1'b0, random_letter());
        end
        check_ctrl();
        drain_fifo();
        ctrl_write(32'h5);
        check_ctrl();
        end_test(4, "FIFO overflow");

        ctrl_write(32'h0);
        for (int i = 0; i < 3; i++) begin
            send_key(1'b0, 1'b0, random_letter());
        end
        ctrl_write(32'h2);
        drain_fifo();
        check_ctrl();
        end_test(5, "irq disabled and flush");

        ctrl_write(32'h1);
        send_frame(random_letter(), 1'b0, 5);
        tick(PS2_TIMEOUT + 50);
        send_key(1'b0, 1'b0, random_letter());
        drain_fifo();
        check_ctrl();
        end_test(6, "abandoned frame");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/kbd_pkg.sv
verilog/kbd_event_if.sv
verilog/ps2_rx.sv
verilog/ps2_kbd.sv
verilog/keycode_rom.sv
verilog/kbd_fifo.sv
verilog/kbd_regs.sv
verilog/kbd_controller.sv
testbench/kbd_controller_assert.sv
testbench/kbd_controller_tb.sv

// ==== Makefile ====
TOP = kbd_controller_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
